// ==== source/hart_pkg.sv ====
// Hart shell register file package
// Word layout with check bits, write port and read request structs
`default_nettype none

package hart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned DataWidth    = 32;
  parameter int unsigned CheckWidth   = 7;
  parameter int unsigned RegAddrWidth = 5;

  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Check bit k covers data bits whose index mod 7 equals k
  typedef struct packed {
    logic [DataWidth-1:0]  data;
    logic [CheckWidth-1:0] check;
  } rf_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    rf_word_t  wdata;
  } rf_write_t;

  typedef struct packed {
    logic      re_a;
    reg_addr_t raddr_a;
    logic      re_b;
    reg_addr_t raddr_b;
  } rf_read_req_t;

endpackage

`default_nettype wire

// ==== source/icache_pkg.sv ====
// Instruction cache RAM package
// Bank geometry, tag and line types and the per-bank request structs
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int unsigned NumWays    = 2;
  parameter int unsigned NumLines   = 64;
  parameter int unsigned IndexWidth = 6;
  // Tag includes the valid bit
  parameter int unsigned TagWidth   = 22;
  // Two 32-bit bus beats
  parameter int unsigned LineWidth  = 64;

  typedef logic [IndexWidth-1:0] ic_index_t;
  typedef logic [TagWidth-1:0]   ic_tag_t;
  typedef logic [LineWidth-1:0]  ic_line_t;

  ////////////////////////////////////////////////////////////////////////////
  // Requests, one req bit per way
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [NumWays-1:0] req;
    logic               write;
    ic_index_t          addr;
    ic_tag_t            wdata;
  } ic_tag_req_t;

  typedef struct packed {
    logic [NumWays-1:0] req;
    logic               write;
    ic_index_t          addr;
    ic_line_t           wdata;
  } ic_data_req_t;

endpackage

`default_nettype wire

// ==== source/ram_1p.sv ====
// Single-port synchronous RAM over a generic payload type
// One access per requested edge, read data registered
`timescale 1ns/1ps
`default_nettype none

module ram_1p #(
  parameter int unsigned Depth     = 64,
  parameter type         payload_t = logic [31:0]
) (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  write_i,
  input  icache_pkg::ic_index_t addr_i,
  input  payload_t              wdata_i,
  output payload_t              rdata_o
);

  payload_t mem [Depth];

  // Read data holds when idle or on a write
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/icache_rams.sv ====
// Instruction cache RAM banks
// One tag bank and one data bank per way, each gated by its own req bit
`timescale 1ns/1ps
`default_nettype none

module icache_rams #(
  parameter int unsigned NumWays  = icache_pkg::NumWays,
  parameter int unsigned NumLines = icache_pkg::NumLines
) (
  input  logic                                 clk_i,
  input  icache_pkg::ic_tag_req_t              tag_req_i,
  input  icache_pkg::ic_data_req_t             data_req_i,
  output icache_pkg::ic_tag_t  [NumWays-1:0]   tag_rdata_o,
  output icache_pkg::ic_line_t [NumWays-1:0]   data_rdata_o
);

  import icache_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Banks per way
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_ways
    // Tag bank
    ram_1p #(
      .Depth    (NumLines),
      .payload_t(ic_tag_t)
    ) tag_bank_i (
      .clk_i  (clk_i),
      .req_i  (tag_req_i.req[w]),
      .write_i(tag_req_i.write),
      .addr_i (tag_req_i.addr),
      .wdata_i(tag_req_i.wdata),
      .rdata_o(tag_rdata_o[w])
    );

    // Data bank
    ram_1p #(
      .Depth    (NumLines),
      .payload_t(ic_line_t)
    ) data_bank_i (
      .clk_i  (clk_i),
      .req_i  (data_req_i.req[w]),
      .write_i(data_req_i.write),
      .addr_i (data_req_i.addr),
      .wdata_i(data_req_i.wdata),
      .rdata_o(data_rdata_o[w])
    );
  end

endmodule

`default_nettype wire

// ==== source/regfile_ff.sv ====
// Flip-flop register file, two combinational read ports, one write port
// Address 0 is hardwired to zero; RV32E keeps only the lower 16 entries
`timescale 1ns/1ps
`default_nettype none

module regfile_ff #(
  parameter bit RV32E = 1'b0
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  hart_pkg::rf_write_t write_i,
  input  hart_pkg::reg_addr_t raddr_a_i,
  input  hart_pkg::reg_addr_t raddr_b_i,
  output hart_pkg::rf_word_t  rdata_a_o,
  output hart_pkg::rf_word_t  rdata_b_o
);

  import hart_pkg::*;

  localparam int unsigned NumWords = RV32E ? 16 : 32;

  rf_word_t             rf_q [1:NumWords-1];
  logic [NumWords-1:1]  we_dec;

  // Write decode, entries past NumWords never match
  always_comb begin
    we_dec = '0;
    for (int i = 1; i < NumWords; i++) begin
      we_dec[i] = write_i.we && (write_i.waddr == reg_addr_t'(i));
    end
  end

  for (genvar i = 1; i < NumWords; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= write_i.wdata;
      end
    end
  end

  // Unmatched addresses fall through to zero
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    for (int i = 1; i < NumWords; i++) begin
      if (raddr_a_i == reg_addr_t'(i)) begin
        rdata_a_o = rf_q[i];
      end
      if (raddr_b_i == reg_addr_t'(i)) begin
        rdata_b_o = rf_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/rf_read_check.sv ====
// Register file read check
// Recomputes check bits of enabled reads and latches a sticky major alert
`timescale 1ns/1ps
`default_nettype none

module rf_read_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  hart_pkg::rf_read_req_t read_i,
  input  hart_pkg::rf_word_t     rdata_a_i,
  input  hart_pkg::rf_word_t     rdata_b_i,
  output logic                   alert_major_o
);

  import hart_pkg::*;

  logic err_a;
  logic err_b;
  logic alert_q;

  // Interleaved parity, bit k folds data bits k, k+7, k+14 ...
  function automatic logic [CheckWidth-1:0] calc_check(logic [DataWidth-1:0] data);
    logic [CheckWidth-1:0] chk;
    chk = '0;
    for (int i = 0; i < DataWidth; i++) begin
      chk[i % CheckWidth] ^= data[i];
    end
    return chk;
  endfunction

  assign err_a = read_i.re_a && (calc_check(rdata_a_i.data) != rdata_a_i.check);
  assign err_b = read_i.re_b && (calc_check(rdata_b_i.data) != rdata_b_i.check);

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (err_a || err_b) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_major_o = alert_q;

endmodule

`default_nettype wire

// ==== source/hart_shell_top.sv ====
// Hart shell top level
// Sleep status, checked flip-flop register file and instruction cache banks
// around an external core
`timescale 1ns/1ps
`default_nettype none

module hart_shell_top #(
  parameter bit RV32E = 1'b0
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Register file
  input  hart_pkg::rf_write_t                           rf_write_i,
  input  hart_pkg::rf_read_req_t                        rf_read_i,
  output hart_pkg::rf_word_t                            rf_rdata_a_o,
  output hart_pkg::rf_word_t                            rf_rdata_b_o,
  // Cache RAMs
  input  icache_pkg::ic_tag_req_t                       ic_tag_req_i,
  input  icache_pkg::ic_data_req_t                      ic_data_req_i,
  output icache_pkg::ic_tag_t  [icache_pkg::NumWays-1:0] ic_tag_rdata_o,
  output icache_pkg::ic_line_t [icache_pkg::NumWays-1:0] ic_data_rdata_o,
  // Status and wake sources
  input  logic                                          core_busy_i,
  input  logic                                          irq_pending_i,
  input  logic                                          irq_nm_i,
  input  logic                                          debug_req_i,
  output logic                                          alert_major_o,
  output logic                                          core_sleep_o
);

  import icache_pkg::*;

  logic core_busy_q;

  ////////////////////////////////////////////////////////////////////////////
  // Sleep status
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the hart awake
  assign core_sleep_o = ~(core_busy_q | debug_req_i | irq_pending_i | irq_nm_i);

  ////////////////////////////////////////////////////////////////////////////
  // Register file and read check
  ////////////////////////////////////////////////////////////////////////////

  regfile_ff #(
    .RV32E(RV32E)
  ) regfile_ff_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .write_i  (rf_write_i),
    .raddr_a_i(rf_read_i.raddr_a),
    .raddr_b_i(rf_read_i.raddr_b),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o)
  );

  rf_read_check rf_read_check_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .read_i       (rf_read_i),
    .rdata_a_i    (rf_rdata_a_o),
    .rdata_b_i    (rf_rdata_b_o),
    .alert_major_o(alert_major_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Cache RAMs
  ////////////////////////////////////////////////////////////////////////////

  icache_rams #(
    .NumWays (NumWays),
    .NumLines(NumLines)
  ) icache_rams_i (
    .clk_i       (clk_i),
    .tag_req_i   (ic_tag_req_i),
    .data_req_i  (ic_data_req_i),
    .tag_rdata_o (ic_tag_rdata_o),
    .data_rdata_o(ic_data_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/hart_shell_properties.sv ====
// Assertions on the hart shell alert and sleep outputs
`timescale 1ns/1ps
`default_nettype none

module hart_shell_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic irq_nm_i,
  input logic debug_req_i,
  input logic alert_major_o,
  input logic core_sleep_o
);

  // Major alert is sticky until reset
  alert_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$fell(alert_major_o))
    else $error("alert_major_o fell while out of reset");

  sleep_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_nm_i || debug_req_i) |-> !core_sleep_o)
    else $error("core_sleep_o high with irq_nm_i or debug_req_i set");

  alert_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o))
    else $error("alert_major_o unknown after reset");

endmodule

bind hart_shell_top hart_shell_properties hart_shell_properties_i (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .irq_nm_i     (irq_nm_i),
  .debug_req_i  (debug_req_i),
  .alert_major_o(alert_major_o),
  .core_sleep_o (core_sleep_o)
);

`default_nettype wire

// ==== tb/tb_hart_shell_top.sv ====
// Testbench for the hart shell top level
// Acts as the core and drives register file, wake and cache RAM traffic
`timescale 1ns/1ps
`default_nettype none

module tb_hart_shell_top;

  import hart_pkg::*;
  import icache_pkg::*;

  // Sum of per-test cycles plus margin
  localparam int unsigned TestCycles    = 140;
  localparam int unsigned TimeoutCycles = TestCycles + 100;

  logic                   clk;
  logic                   rst_n;
  rf_write_t              rf_write;
  rf_read_req_t           rf_read;
  ic_tag_req_t            tag_req;
  ic_data_req_t           data_req;
  logic                   core_busy;
  logic                   irq_pending;
  logic                   irq_nm;
  logic                   debug_req;
  rf_word_t               rdata_a;
  rf_word_t               rdata_b;
  ic_tag_t  [NumWays-1:0] tag_rdata;
  ic_line_t [NumWays-1:0] data_rdata;
  logic                   alert_major;
  logic                   core_sleep;
  int unsigned            errors = 0;
  int unsigned            cycles = 0;
  ic_index_t              idx      [4];
  ic_tag_t                exp_tag  [NumWays][4];
  ic_line_t               exp_line [NumWays][4];

  hart_shell_top #(
    .RV32E(1'b1)
  ) hart_shell_top_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .rf_write_i     (rf_write),
    .rf_read_i      (rf_read),
    .rf_rdata_a_o   (rdata_a),
    .rf_rdata_b_o   (rdata_b),
    .ic_tag_req_i   (tag_req),
    .ic_data_req_i  (data_req),
    .ic_tag_rdata_o (tag_rdata),
    .ic_data_rdata_o(data_rdata),
    .core_busy_i    (core_busy),
    .irq_pending_i  (irq_pending),
    .irq_nm_i       (irq_nm),
    .debug_req_i    (debug_req),
    .alert_major_o  (alert_major),
    .core_sleep_o   (core_sleep)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Bit k is the XOR of data bits k, k+7, k+14 ...
  function automatic logic [CheckWidth-1:0] check_bits(logic [DataWidth-1:0] data);
    logic [CheckWidth-1:0] bits;
    bits = '0;
    for (int k = 0; k < CheckWidth; k++) begin
      for (int j = k; j < DataWidth; j += CheckWidth) begin
        bits[k] = bits[k] ^ data[j];
      end
    end
    return bits;
  endfunction

  function automatic rf_word_t random_word();
    rf_word_t word;
    word.data  = $urandom();
    word.check = check_bits(word.data);
    return word;
  endfunction

  task automatic check_word(input string name, input rf_word_t exp, input rf_word_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input ic_tag_t exp, input ic_tag_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_line(input string name, input ic_line_t exp, input ic_line_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_reg(input reg_addr_t addr, input rf_word_t word);
    @(posedge clk);
    rf_write <= '{we: 1'b1, waddr: addr, wdata: word};
  endtask

  // Returns at the negedge where the read data is stable
  task automatic read_regs(input reg_addr_t addr_a, input reg_addr_t addr_b, input logic re);
    @(posedge clk);
    rf_write <= '0;
    rf_read  <= '{re_a: re, raddr_a: addr_a, re_b: re, raddr_b: addr_b};
    @(negedge clk);
  endtask

  task automatic drive_rams(input ic_tag_req_t treq, input ic_data_req_t dreq);
    @(posedge clk);
    tag_req  <= treq;
    data_req <= dreq;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    read_regs(5'd1, 5'd15, 1'b1);
    check_flag("core_sleep_o", 1'b1, core_sleep);
    check_flag("alert_major_o", 1'b0, alert_major);
    check_word("rf_rdata_a_o", '0, rdata_a);
    check_word("rf_rdata_b_o", '0, rdata_b);
  endtask

  task automatic regfile_access();
    rf_word_t word;
    rf_word_t word_1;
    rf_word_t word_15;
    word_1  = '0;
    word_15 = '0;
    for (int a = 0; a < 32; a++) begin
      word = random_word();
      write_reg(reg_addr_t'(a), word);
      // Zero register and the upper half in RV32E
      if (a == 0 || a >= 16) begin
        word = '0;
      end
      if (a == 1) begin
        word_1 = word;
      end
      if (a == 15) begin
        word_15 = word;
      end
      read_regs(reg_addr_t'(a), reg_addr_t'(a), 1'b1);
      check_word("rf_rdata_a_o", word, rdata_a);
      check_word("rf_rdata_b_o", word, rdata_b);
      check_flag("alert_major_o", 1'b0, alert_major);
    end
    // Crossed addresses keep the two ports apart
    read_regs(5'd15, 5'd1, 1'b1);
    check_word("rf_rdata_a_o", word_15, rdata_a);
    check_word("rf_rdata_b_o", word_1, rdata_b);
    check_flag("alert_major_o", 1'b0, alert_major);
  endtask

  task automatic sleep_and_wake();
    @(posedge clk);
    core_busy <= 1'b1;
    @(negedge clk);
    check_flag("core_sleep_o", 1'b1, core_sleep);
    @(negedge clk);
    check_flag("core_sleep_o", 1'b0, core_sleep);
    @(posedge clk);
    core_busy <= 1'b0;
    @(negedge clk);
    check_flag("core_sleep_o", 1'b0, core_sleep);
    @(negedge clk);
    check_flag("core_sleep_o", 1'b1, core_sleep);
    // One wake source at a time
    for (int s = 0; s < 3; s++) begin
      @(posedge clk);
      {irq_pending, irq_nm, debug_req} <= 3'b100 >> s;
      @(negedge clk);
      check_flag("core_sleep_o", 1'b0, core_sleep);
      @(posedge clk);
      {irq_pending, irq_nm, debug_req} <= 3'b000;
      @(negedge clk);
      check_flag("core_sleep_o", 1'b1, core_sleep);
    end
  endtask

  task automatic tag_bank_access();
    ic_tag_req_t treq;
    for (int w = 0; w < NumWays; w++) begin
      for (int k = 0; k < 4; k++) begin
        exp_tag[w][k] = ic_tag_t'($urandom());
        treq = '{req: NumWays'(1) << w, write: 1'b1, addr: idx[k], wdata: exp_tag[w][k]};
        drive_rams(treq, '0);
      end
    end
    for (int k = 0; k < 4; k++) begin
      treq = '{req: '1, write: 1'b0, addr: idx[k], wdata: '0};
      drive_rams(treq, '0);
      drive_rams('0, '0);
      @(negedge clk);
      for (int w = 0; w < NumWays; w++) begin
        check_tag("ic_tag_rdata_o", exp_tag[w][k], tag_rdata[w]);
      end
    end
    repeat (2) @(negedge clk);
    for (int w = 0; w < NumWays; w++) begin
      check_tag("ic_tag_rdata_o", exp_tag[w][3], tag_rdata[w]);
    end
  endtask

  task automatic data_bank_access();
    ic_tag_req_t  treq;
    ic_data_req_t dreq;
    // Line writes share cycles with tag reads
    for (int w = 0; w < NumWays; w++) begin
      for (int k = 0; k < 4; k++) begin
        exp_line[w][k] = {$urandom(), $urandom()};
        treq = '{req: '1, write: 1'b0, addr: idx[k], wdata: '0};
        dreq = '{req: NumWays'(1) << w, write: 1'b1, addr: idx[k], wdata: exp_line[w][k]};
        drive_rams(treq, dreq);
        drive_rams('0, '0);
        @(negedge clk);
        for (int v = 0; v < NumWays; v++) begin
          check_tag("ic_tag_rdata_o", exp_tag[v][k], tag_rdata[v]);
        end
      end
    end
    for (int k = 0; k < 4; k++) begin
      dreq = '{req: '1, write: 1'b0, addr: idx[k], wdata: '0};
      drive_rams('0, dreq);
      drive_rams('0, '0);
      @(negedge clk);
      for (int w = 0; w < NumWays; w++) begin
        check_line("ic_data_rdata_o", exp_line[w][k], data_rdata[w]);
        check_tag("ic_tag_rdata_o", exp_tag[w][3], tag_rdata[w]);
      end
    end
  endtask

  task automatic read_check_alert();
    rf_word_t bad;
    bad = random_word();
    bad.check = bad.check ^ (CheckWidth'(1) << $urandom_range(CheckWidth - 1));
    write_reg(5'd5, bad);
    read_regs(5'd5, 5'd5, 1'b0);
    check_word("rf_rdata_a_o", bad, rdata_a);
    @(negedge clk);
    check_flag("alert_major_o", 1'b0, alert_major);
    read_regs(5'd5, 5'd5, 1'b1);
    check_flag("alert_major_o", 1'b0, alert_major);
    @(negedge clk);
    check_flag("alert_major_o", 1'b1, alert_major);
    for (int a = 1; a < 4; a++) begin
      read_regs(reg_addr_t'(a), reg_addr_t'(a), 1'b1);
      check_flag("alert_major_o", 1'b1, alert_major);
    end
  endtask

  initial begin
    void'($urandom(98390));
    rst_n       <= 1'b0;
    rf_write    <= '0;
    rf_read     <= '0;
    tag_req     <= '0;
    data_req    <= '0;
    core_busy   <= 1'b0;
    irq_pending <= 1'b0;
    irq_nm      <= 1'b0;
    debug_req   <= 1'b0;
    // Four distinct line indices, one per quarter
    for (int k = 0; k < 4; k++) begin
      idx[k] = ic_index_t'(k * 16 + $urandom_range(15));
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    regfile_access();
    sleep_and_wake();
    tag_bank_access();
    data_bank_access();
    read_check_alert();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/hart_pkg.sv
source/icache_pkg.sv
source/ram_1p.sv
source/icache_rams.sv
source/regfile_ff.sv
source/rf_read_check.sv
source/hart_shell_top.sv
tb/hart_shell_properties.sv
tb/tb_hart_shell_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the hart shell testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

if ! verilator --binary --timing --assert -f files.f \
    --top-module tb_hart_shell_top -Mdir "$build_dir" -o sim; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1
